// File: design/dMemPkg.sv
package dMemPkg;

   //====================
   // Vector types
   //====================
   typedef logic [31:0] tAddr;    // Byte address
   typedef logic [31:0] tData;    // Data word
   typedef logic [3:0]  tByteEn;  // One bit per byte of tData
   typedef logic [9:0]  tPixCnt;  // VGA X or Y counter
   typedef logic [3:0]  tColor;   // One colour channel

   // One-hot region of the Q104H response
   typedef enum logic [3:0] {
      REGION_NONE = 4'b0001,
      REGION_RAM  = 4'b0010,
      REGION_CR   = 4'b0100,
      REGION_VGA  = 4'b1000
   } tRegion;

   //====================
   // Memory map
   //====================
   localparam int REGION_MASK_BITS = 16;  // Offset bits inside a region window

   localparam tAddr RAM_BASE = 32'h0001_0000;
   localparam tAddr CR_BASE  = 32'h00C0_0000;
   localparam tAddr VGA_BASE = 32'h00FF_0000;

   // Control register byte offsets
   localparam logic [REGION_MASK_BITS-1:0] CR_LED  = 16'h0000;
   localparam logic [REGION_MASK_BITS-1:0] CR_SEG  = 16'h0004;
   localparam logic [REGION_MASK_BITS-1:0] CR_SW   = 16'h0008;  // Read only
   localparam logic [REGION_MASK_BITS-1:0] CR_BTN  = 16'h000C;  // Read only
   localparam logic [REGION_MASK_BITS-1:0] CR_VGAX = 16'h0010;  // Read only
   localparam logic [REGION_MASK_BITS-1:0] CR_VGAY = 16'h0014;  // Read only

endpackage

// File: design/regionDecode.sv
`timescale 1ns/1ps

module regionDecode
   import dMemPkg::*;
(
   input  logic   Clock,
   input  logic   rstN,
   input  tAddr   reqAddrQ103H,
   input  logic   reqRdEnQ103H,
   output logic   matchRamQ103H,
   output logic   matchCrQ103H,
   output logic   matchVgaQ103H,
   output tRegion regionQ104H
);

   tRegion regionQ103H;

   // Window compare on the bits above the region offset
   assign matchRamQ103H = (reqAddrQ103H[31:REGION_MASK_BITS] == RAM_BASE[31:REGION_MASK_BITS]);
   assign matchCrQ103H  = (reqAddrQ103H[31:REGION_MASK_BITS] == CR_BASE[31:REGION_MASK_BITS]);
   assign matchVgaQ103H = (reqAddrQ103H[31:REGION_MASK_BITS] == VGA_BASE[31:REGION_MASK_BITS]);

   // Only a read selects a response source
   always_comb begin
      regionQ103H = REGION_NONE;
      if (reqRdEnQ103H) begin
         if (matchRamQ103H)      regionQ103H = REGION_RAM;
         else if (matchCrQ103H)  regionQ103H = REGION_CR;
         else if (matchVgaQ103H) regionQ103H = REGION_VGA;
      end
   end

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         regionQ104H <= REGION_NONE;
      end else begin
         regionQ104H <= regionQ103H;  // Steers rdRspSel next cycle
      end
   end

endmodule

// File: design/dataRam.sv
`timescale 1ns/1ps

module dataRam
   import dMemPkg::*;
#(
   parameter int RAM_WORDS = 1024
) (
   input  logic   Clock,
   input  logic   rstN,
   input  tAddr   reqAddrQ103H,
   input  tData   reqDataQ103H,
   input  tByteEn reqByteEnQ103H,
   input  logic   reqWrEnQ103H,
   input  logic   reqRdEnQ103H,
   input  logic   matchRamQ103H,
   output tData   ramRdDataQ104H
);

   localparam int IDX_W = $clog2(RAM_WORDS);

   tData             mem [RAM_WORDS];
   logic [IDX_W-1:0] wordIdx;
   logic             ramWr;
   logic             ramRd;

   // Word index, upper address bits drop out so the RAM aliases
   assign wordIdx = reqAddrQ103H[IDX_W+1:2];

   assign ramWr = reqWrEnQ103H && matchRamQ103H;
   assign ramRd = reqRdEnQ103H && matchRamQ103H;

   //====================
   // Write port
   //====================
   always_ff @(posedge Clock) begin
      if (ramWr) begin
         for (int i = 0; i < 4; i++) begin
            if (reqByteEnQ103H[i]) begin
               mem[wordIdx][i*8 +: 8] <= reqDataQ103H[i*8 +: 8];  // Byte lane i
            end
         end
      end
   end

   //====================
   // Read port
   //====================
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         ramRdDataQ104H <= '0;
      end else if (ramRd) begin
         ramRdDataQ104H <= mem[wordIdx];  // Full word, core aligns
      end
   end

endmodule

// File: design/crMem.sv
`timescale 1ns/1ps

module crMem
   import dMemPkg::*;
(
   input  logic        Clock,
   input  logic        rstN,
   input  tAddr        reqAddrQ103H,
   input  tData        reqDataQ103H,
   input  tByteEn      reqByteEnQ103H,
   input  logic        reqWrEnQ103H,
   input  logic        reqRdEnQ103H,
   input  logic        matchCrQ103H,
   input  logic [9:0]  switches,
   input  logic [1:0]  buttons,
   input  tPixCnt      vgaCounterX,
   input  tPixCnt      vgaCounterY,
   output tData        crRdDataQ104H,
   output logic [9:0]  leds,
   output logic [23:0] sevenSeg
);

   logic [REGION_MASK_BITS-1:0] crOffset;
   logic                        crWr;
   logic                        crRd;
   tData                        ledMerge;
   tData                        segMerge;
   tData                        crRdWord;
   logic [9:0]                  swMeta, swSync;
   logic [1:0]                  btnMeta, btnSync;

   // Byte-lane merge of a write into an existing word
   function automatic tData mergeBytes(tData oldWord, tData newWord, tByteEn byteEn);
      tData merged;
      merged = oldWord;
      for (int i = 0; i < 4; i++) begin
         if (byteEn[i]) merged[i*8 +: 8] = newWord[i*8 +: 8];
      end
      return merged;
   endfunction

   assign crOffset = reqAddrQ103H[REGION_MASK_BITS-1:0];
   assign crWr     = reqWrEnQ103H && matchCrQ103H;
   assign crRd     = reqRdEnQ103H && matchCrQ103H;
   assign ledMerge = mergeBytes(tData'(leds), reqDataQ103H, reqByteEnQ103H);
   assign segMerge = mergeBytes(tData'(sevenSeg), reqDataQ103H, reqByteEnQ103H);

   //====================
   // Writable registers
   //====================
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         leds     <= '0;
         sevenSeg <= '0;
      end else if (crWr) begin
         if (crOffset == CR_LED) leds     <= ledMerge[9:0];
         if (crOffset == CR_SEG) sevenSeg <= segMerge[23:0];
         // Other offsets are read only or unmapped
      end
   end

   // Two-flop synchroniser for board inputs
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         swMeta  <= '0;
         swSync  <= '0;
         btnMeta <= '0;
         btnSync <= '0;
      end else begin
         swMeta  <= switches;
         swSync  <= swMeta;
         btnMeta <= buttons;
         btnSync <= btnMeta;
      end
   end

   //====================
   // Read path
   //====================
   always_comb begin
      case (crOffset)
         CR_LED:  crRdWord = tData'(leds);
         CR_SEG:  crRdWord = tData'(sevenSeg);
         CR_SW:   crRdWord = tData'(swSync);
         CR_BTN:  crRdWord = tData'(btnSync);
         CR_VGAX: crRdWord = tData'(vgaCounterX);  // Counter at request cycle
         CR_VGAY: crRdWord = tData'(vgaCounterY);
         default: crRdWord = '0;                   // Unknown offset
      endcase
   end

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         crRdDataQ104H <= '0;
      end else if (crRd) begin
         crRdDataQ104H <= crRdWord;
      end
   end

endmodule

// File: design/vgaCtrl.sv
`timescale 1ns/1ps

module vgaCtrl
   import dMemPkg::*;
#(
   parameter int H_ACTIVE = 640,
   parameter int H_FRONT  = 16,
   parameter int H_SYNC   = 96,
   parameter int H_BACK   = 48,
   parameter int V_ACTIVE = 480,
   parameter int V_FRONT  = 10,
   parameter int V_SYNC   = 2,
   parameter int V_BACK   = 33
) (
   input  logic   Clock,
   input  logic   rstN,
   input  tAddr   reqAddrQ103H,
   input  tData   reqDataQ103H,
   input  tByteEn reqByteEnQ103H,
   input  logic   reqWrEnQ103H,
   input  logic   reqRdEnQ103H,
   input  logic   matchVgaQ103H,
   output tData   vgaRdDataQ104H,
   output tPixCnt vgaCounterX,
   output tPixCnt vgaCounterY,
   output tColor  vgaRed,
   output tColor  vgaGreen,
   output tColor  vgaBlue,
   output logic   hSync,
   output logic   vSync,
   output logic   inDisplayArea
);

   localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
   localparam int FB_WORDS = H_ACTIVE * V_ACTIVE / 32;  // One bit per pixel
   localparam int FB_AW    = $clog2(FB_WORDS);

   tData              fb [FB_WORDS];
   logic [FB_AW-1:0]  coreIdx;
   logic              fbWr, fbRd;
   logic              pixEn;
   tPixCnt            xNext, yNext;
   logic              dispNext;
   logic [31:0]       pixIdx;
   logic              pixOn;

   //====================
   // Core port
   //====================
   assign coreIdx = reqAddrQ103H[FB_AW+1:2];
   assign fbWr    = reqWrEnQ103H && matchVgaQ103H;
   assign fbRd    = reqRdEnQ103H && matchVgaQ103H;

   always_ff @(posedge Clock) begin
      if (fbWr) begin
         for (int i = 0; i < 4; i++) begin
            if (reqByteEnQ103H[i]) fb[coreIdx][i*8 +: 8] <= reqDataQ103H[i*8 +: 8];
         end
      end
   end

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) vgaRdDataQ104H <= '0;
      else if (fbRd) vgaRdDataQ104H <= fb[coreIdx];
   end

   //====================
   // Scan timing
   //====================
   always_comb begin
      xNext = vgaCounterX;
      yNext = vgaCounterY;
      if (pixEn) begin  // Advance on every second clock
         if (vgaCounterX == tPixCnt'(H_TOTAL - 1)) begin
            xNext = '0;
            yNext = (vgaCounterY == tPixCnt'(V_TOTAL - 1)) ? '0 : vgaCounterY + 1'b1;
         end else begin
            xNext = vgaCounterX + 1'b1;
         end
      end
   end

   assign dispNext = (xNext < H_ACTIVE) && (yNext < V_ACTIVE);
   assign pixIdx   = yNext * H_ACTIVE + xNext;          // Bit 0 of word 0 is pixel 0
   assign pixOn    = dispNext && fb[pixIdx[FB_AW+4:5]][pixIdx[4:0]];  // Gated outside frame

   // Outputs register together with the counters they describe
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         pixEn         <= 1'b1;
         vgaCounterX   <= '0;
         vgaCounterY   <= '0;
         hSync         <= 1'b1;  // Inactive
         vSync         <= 1'b1;
         inDisplayArea <= 1'b1;  // Pixel (0,0)
         vgaRed        <= '0;
         vgaGreen      <= '0;
         vgaBlue       <= '0;
      end else begin
         pixEn         <= ~pixEn;
         vgaCounterX   <= xNext;
         vgaCounterY   <= yNext;
         hSync         <= !((xNext >= H_ACTIVE + H_FRONT) &&
                            (xNext <  H_ACTIVE + H_FRONT + H_SYNC));
         vSync         <= !((yNext >= V_ACTIVE + V_FRONT) &&
                            (yNext <  V_ACTIVE + V_FRONT + V_SYNC));
         inDisplayArea <= dispNext;
         vgaRed        <= {4{pixOn}};  // Monochrome, white when set
         vgaGreen      <= {4{pixOn}};
         vgaBlue       <= {4{pixOn}};
      end
   end

endmodule

// File: design/rdRspSel.sv
`timescale 1ns/1ps

module rdRspSel
   import dMemPkg::*;
(
   input  tRegion regionQ104H,
   input  tData   ramRdDataQ104H,
   input  tData   crRdDataQ104H,
   input  tData   vgaRdDataQ104H,
   output tData   rdDataQ104H
);

   //====================
   // Result select
   //====================
   // Region was registered with the read, so it lines up with the data
   always_comb begin
      case (regionQ104H)
         REGION_RAM: rdDataQ104H = ramRdDataQ104H;
         REGION_CR:  rdDataQ104H = crRdDataQ104H;
         REGION_VGA: rdDataQ104H = vgaRdDataQ104H;
         REGION_NONE: begin
            rdDataQ104H = '0;  // Unmapped read or no read at all
         end
         default:    rdDataQ104H = '0;
      endcase
   end

endmodule

// File: design/dMemSubsystem.sv
`timescale 1ns/1ps

module dMemSubsystem
   import dMemPkg::*;
#(
   parameter int RAM_WORDS = 1024,
   parameter int H_ACTIVE  = 640,
   parameter int H_FRONT   = 16,
   parameter int H_SYNC    = 96,
   parameter int H_BACK    = 48,
   parameter int V_ACTIVE  = 480,
   parameter int V_FRONT   = 10,
   parameter int V_SYNC    = 2,
   parameter int V_BACK    = 33
) (
   input  logic        Clock,
   input  logic        rstN,
   // Core request, stage Q103H
   input  tAddr        reqAddrQ103H,
   input  tData        reqDataQ103H,
   input  tByteEn      reqByteEnQ103H,
   input  logic        reqWrEnQ103H,
   input  logic        reqRdEnQ103H,
   output tData        rdDataQ104H,     // One cycle after the read
   // Board
   input  logic [9:0]  switches,
   input  logic [1:0]  buttons,
   output logic [9:0]  leds,
   output logic [23:0] sevenSeg,
   // VGA
   output tColor       vgaRed,
   output tColor       vgaGreen,
   output tColor       vgaBlue,
   output logic        hSync,
   output logic        vSync,
   output logic        inDisplayArea
);

   logic   matchRamQ103H, matchCrQ103H, matchVgaQ103H;
   tRegion regionQ104H;
   tData   ramRdDataQ104H, crRdDataQ104H, vgaRdDataQ104H;
   tPixCnt vgaCounterX, vgaCounterY;

   //====================
   // Decode
   //====================
   regionDecode regionDecode_inst (
      .Clock, .rstN, .reqAddrQ103H, .reqRdEnQ103H,
      .matchRamQ103H, .matchCrQ103H, .matchVgaQ103H, .regionQ104H
   );

   //====================
   // Targets
   //====================
   dataRam #(.RAM_WORDS(RAM_WORDS)) dataRam_inst (
      .Clock, .rstN, .reqAddrQ103H, .reqDataQ103H, .reqByteEnQ103H,
      .reqWrEnQ103H, .reqRdEnQ103H, .matchRamQ103H, .ramRdDataQ104H
   );

   crMem crMem_inst (
      .Clock, .rstN, .reqAddrQ103H, .reqDataQ103H, .reqByteEnQ103H,
      .reqWrEnQ103H, .reqRdEnQ103H, .matchCrQ103H, .switches, .buttons,
      .vgaCounterX, .vgaCounterY, .crRdDataQ104H, .leds, .sevenSeg
   );

   vgaCtrl #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
   ) vgaCtrl_inst (
      .Clock, .rstN, .reqAddrQ103H, .reqDataQ103H, .reqByteEnQ103H,
      .reqWrEnQ103H, .reqRdEnQ103H, .matchVgaQ103H, .vgaRdDataQ104H,
      .vgaCounterX, .vgaCounterY, .vgaRed, .vgaGreen, .vgaBlue,
      .hSync, .vSync, .inDisplayArea
   );

   //====================
   // Result
   //====================
   rdRspSel rdRspSel_inst (
      .regionQ104H, .ramRdDataQ104H, .crRdDataQ104H, .vgaRdDataQ104H, .rdDataQ104H
   );

endmodule

// File: test/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
   parameter int PERIOD       = 40,  // ns
   parameter int RESET_CYCLES = 2
) (
   output logic Clock,
   output logic rstN
);

   initial begin
      Clock = 1'b0;
      forever #(PERIOD / 2) Clock = ~Clock;
   end

   // Reset held over the first rising edges
   initial begin
      rstN = 1'b0;
      repeat (RESET_CYCLES) @(posedge Clock);
      rstN <= 1'b1;  // Released after the last reset edge
   end

endmodule

// File: test/tbMonitor.sv
`timescale 1ns/1ps

module tbMonitor
   import dMemPkg::*;
#(
   parameter int H_ACTIVE = 640,
   parameter int H_FRONT  = 16,
   parameter int H_SYNC   = 96,
   parameter int H_BACK   = 48,
   parameter int V_ACTIVE = 480,
   parameter int V_FRONT  = 10,
   parameter int V_SYNC   = 2,
   parameter int V_BACK   = 33
) (
   input  logic        Clock,
   input  logic        rstN,
   input  tAddr        reqAddrQ103H,
   input  tData        reqDataQ103H,
   input  tByteEn      reqByteEnQ103H,
   input  logic        reqWrEnQ103H,
   input  logic        reqRdEnQ103H,
   input  tData        expRdData,     // From the stimulus table
   input  logic [1:0]  checkKind,
   input  tData        rdDataQ104H,
   input  logic [9:0]  leds,
   input  logic [23:0] sevenSeg,
   input  tColor       vgaRed,
   input  tColor       vgaGreen,
   input  tColor       vgaBlue,
   input  logic        hSync,
   input  logic        vSync,
   input  logic        inDisplayArea,
   input  logic        finishRun,
   input  int          assertErrs,
   output int          errCount
);

   localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
   localparam int FB_WORDS = H_ACTIVE * V_ACTIVE / 32;
   localparam logic [1:0] KIND_VGAX = 2'd2;  // Expected word is the X model

   int unsigned x, y;               // Scan model
   logic        pixEn;
   logic        hExp, vExp, dispExp;
   logic        colorExp, colorKnown;
   tData        fbModel [FB_WORDS];
   tData        fbKnown [FB_WORDS];  // Bits written so far
   logic [9:0]  ledModel;
   logic [23:0] segModel;
   logic        pendValid;          // Read answer due this cycle
   tData        pendExp;
   int          checkCount;

   function automatic tData laneMask(tByteEn byteEn);
      return {{8{byteEn[3]}}, {8{byteEn[2]}}, {8{byteEn[1]}}, {8{byteEn[0]}}};
   endfunction

   function automatic tData mergeLanes(tData oldWord, tData newWord, tByteEn byteEn);
      return (oldWord & ~laneMask(byteEn)) | (newWord & laneMask(byteEn));
   endfunction

   task automatic expectEq(string name, tData expVal, tData gotVal);
      checkCount++;
      if (gotVal !== expVal) begin
         errCount++;
         $display("Error at %0t ns: %s expected %h, got %h", $time, name, expVal, gotVal);
      end
   endtask

   initial begin
      errCount   = 0;
      checkCount = 0;
      pendValid  = 1'b0;
      for (int i = 0; i < FB_WORDS; i++) fbKnown[i] = '0;
   end

   //====================
   // Model update
   //====================
   // Request inputs still hold the values this edge samples
   always @(posedge Clock) begin
      tData merged;
      int   fbIdx;
      int   pixIdx;
      if (!rstN) begin
         x          = 0;
         y          = 0;
         pixEn      = 1'b1;
         hExp       = 1'b1;
         vExp       = 1'b1;
         dispExp    = 1'b1;  // Pixel (0,0)
         colorExp   = 1'b0;
         colorKnown = 1'b1;
         ledModel   = '0;
         segModel   = '0;
         pendValid  = 1'b0;
      end else begin
         pendValid = reqRdEnQ103H && (checkKind != 2'd0);
         pendExp   = (checkKind == KIND_VGAX) ? tData'(x) : expRdData;  // X of request cycle
         if (pixEn) begin
            if (x == H_TOTAL - 1) begin
               x = 0;
               y = (y == V_TOTAL - 1) ? 0 : y + 1;  // Line wrap steps Y
            end else begin
               x = x + 1;
            end
         end
         pixEn   = !pixEn;
         hExp    = !(x >= H_ACTIVE + H_FRONT && x < H_ACTIVE + H_FRONT + H_SYNC);
         vExp    = !(y >= V_ACTIVE + V_FRONT && y < V_ACTIVE + V_FRONT + V_SYNC);
         dispExp = (x < H_ACTIVE) && (y < V_ACTIVE);
         if (dispExp) begin
            pixIdx     = y * H_ACTIVE + x;  // Bit 0 of word 0 is pixel 0
            colorKnown = fbKnown[pixIdx / 32][pixIdx % 32];
            colorExp   = fbModel[pixIdx / 32][pixIdx % 32];
         end else begin
            colorKnown = 1'b1;
            colorExp   = 1'b0;  // Blanked
         end
         // Writes land after this edge's pixel lookup
         if (reqWrEnQ103H && reqAddrQ103H[31:16] == VGA_BASE[31:16]) begin
            fbIdx          = (reqAddrQ103H[15:0] >> 2) % FB_WORDS;
            fbModel[fbIdx] = mergeLanes(fbModel[fbIdx], reqDataQ103H, reqByteEnQ103H);
            fbKnown[fbIdx] = fbKnown[fbIdx] | laneMask(reqByteEnQ103H);
         end
         if (reqWrEnQ103H && reqAddrQ103H[31:16] == CR_BASE[31:16]) begin
            if (reqAddrQ103H[15:0] == CR_LED) begin
               merged   = mergeLanes(tData'(ledModel), reqDataQ103H, reqByteEnQ103H);
               ledModel = merged[9:0];
            end
            if (reqAddrQ103H[15:0] == CR_SEG) begin
               merged   = mergeLanes(tData'(segModel), reqDataQ103H, reqByteEnQ103H);
               segModel = merged[23:0];
            end
         end
      end
   end

   //====================
   // Compare
   //====================
   always @(negedge Clock) begin
      if (rstN) begin
         if (pendValid) expectEq("rdDataQ104H", pendExp, rdDataQ104H);
         expectEq("leds", tData'(ledModel), tData'(leds));
         expectEq("sevenSeg", tData'(segModel), tData'(sevenSeg));
         expectEq("hSync", tData'(hExp), tData'(hSync));
         expectEq("vSync", tData'(vExp), tData'(vSync));
         expectEq("inDisplayArea", tData'(dispExp), tData'(inDisplayArea));
         if (colorKnown) begin  // Unwritten pixels skipped
            expectEq("vgaRed", tData'({4{colorExp}}), tData'(vgaRed));
            expectEq("vgaGreen", tData'({4{colorExp}}), tData'(vgaGreen));
            expectEq("vgaBlue", tData'({4{colorExp}}), tData'(vgaBlue));
         end
      end
   end

   always @(posedge finishRun) begin
      $display("Checks %0d, data errors %0d, assertion errors %0d",
               checkCount, errCount, assertErrs);
   end

endmodule

// File: test/dMemSubsystem_chk.sv
`timescale 1ns/1ps

module dMemSubsystem_chk
   import dMemPkg::*;
(
   input logic Clock,
   input logic rstN,
   input logic reqWrEnQ103H,
   input logic reqRdEnQ103H,
   input logic matchRamQ103H,
   input logic matchCrQ103H,
   input logic matchVgaQ103H,
   input logic hSync,
   input logic inDisplayArea,
   input tData rdDataQ104H
);

   int failCount;  // Read by the testbench top

   initial failCount = 0;

   // Region windows never overlap
   oneMatch: assert property (@(posedge Clock) disable iff (!rstN)
      $onehot0({matchRamQ103H, matchCrQ103H, matchVgaQ103H}))
   else begin
      failCount++;
      $error("More than one region match is high");
   end

   // Sync pulse sits in the blanking interval
   syncBlank: assert property (@(posedge Clock) disable iff (!rstN)
      !(!hSync && inDisplayArea))
   else begin
      failCount++;
      $error("hSync low inside the display area");
   end

   idleZero: assert property (@(posedge Clock) disable iff (!rstN)
      (!reqRdEnQ103H && !reqWrEnQ103H) |=> (rdDataQ104H == '0))
   else begin
      failCount++;
      $error("Read data not zero after an idle cycle");
   end

endmodule

// File: test/tb.sv
`timescale 1ns/1ps

module tb
   import dMemPkg::*;
();

   //====================
   // Configuration
   //====================
   localparam int RAM_WORDS    = 64;  // Small, so aliasing is near
   localparam int H_ACTIVE     = 32;
   localparam int H_FRONT      = 2;
   localparam int H_SYNC       = 4;
   localparam int H_BACK       = 2;
   localparam int V_ACTIVE     = 8;
   localparam int V_FRONT      = 2;
   localparam int V_SYNC       = 4;
   localparam int V_BACK       = 2;
   localparam int FB_WORDS     = H_ACTIVE * V_ACTIVE / 32;
   localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
   localparam int FRAME_CYCLES = 2 * H_TOTAL * V_TOTAL;  // Pixel enable every second clock

   localparam logic [1:0] CHK_NONE = 2'd0;
   localparam logic [1:0] CHK_WORD = 2'd1;
   localparam logic [1:0] CHK_VGAX = 2'd2;  // Monitor supplies the value

   typedef struct {
      tAddr       addr;
      tData       data;
      tByteEn     byteEn;
      logic       wr;
      logic       rd;
      logic [1:0] kind;
      tData       expWord;
      logic [9:0] sw;
      logic [1:0] btn;
   } tStim;

   logic        Clock, rstN;
   tAddr        reqAddrQ103H;
   tData        reqDataQ103H;
   tByteEn      reqByteEnQ103H;
   logic        reqWrEnQ103H, reqRdEnQ103H;
   tData        rdDataQ104H;
   logic [9:0]  switches, leds;
   logic [1:0]  buttons;
   logic [23:0] sevenSeg;
   tColor       vgaRed, vgaGreen, vgaBlue;
   logic        hSync, vSync, inDisplayArea;
   tData        expRdData;
   logic [1:0]  checkKind;
   logic        finishRun;
   int          errCount, assertErrs;

   tStim        stimTable[$];
   int          seed;
   tData        ramShadow [RAM_WORDS];  // Expected contents while building
   tData        fbShadow [FB_WORDS];
   logic [9:0]  ledShadow, swNow;
   logic [23:0] segShadow;
   logic [1:0]  btnNow;

   //====================
   // Instances
   //====================
   tbClock #(.PERIOD(40), .RESET_CYCLES(2)) tbClock_inst (.Clock, .rstN);

   dMemSubsystem #(
      .RAM_WORDS(RAM_WORDS),
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
   ) dMemSubsystem_inst (
      .Clock, .rstN, .reqAddrQ103H, .reqDataQ103H, .reqByteEnQ103H,
      .reqWrEnQ103H, .reqRdEnQ103H, .rdDataQ104H, .switches, .buttons,
      .leds, .sevenSeg, .vgaRed, .vgaGreen, .vgaBlue, .hSync, .vSync, .inDisplayArea
   );

   bind dMemSubsystem dMemSubsystem_chk dMemSubsystem_chk_inst (
      .Clock, .rstN, .reqWrEnQ103H, .reqRdEnQ103H, .matchRamQ103H, .matchCrQ103H,
      .matchVgaQ103H, .hSync, .inDisplayArea, .rdDataQ104H
   );

   assign assertErrs = dMemSubsystem_inst.dMemSubsystem_chk_inst.failCount;

   tbMonitor #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
   ) tbMonitor_inst (
      .Clock, .rstN, .reqAddrQ103H, .reqDataQ103H, .reqByteEnQ103H, .reqWrEnQ103H,
      .reqRdEnQ103H, .expRdData, .checkKind, .rdDataQ104H, .leds, .sevenSeg,
      .vgaRed, .vgaGreen, .vgaBlue, .hSync, .vSync, .inDisplayArea,
      .finishRun, .assertErrs, .errCount
   );

   //====================
   // Table building
   //====================
   function automatic tData byteMerge(tData oldWord, tData newWord, tByteEn byteEn);
      tData mask;
      mask = {{8{byteEn[3]}}, {8{byteEn[2]}}, {8{byteEn[1]}}, {8{byteEn[0]}}};
      return (oldWord & ~mask) | (newWord & mask);
   endfunction

   task automatic pushEntry(tAddr addr, tData data, tByteEn byteEn, logic wr, logic rd,
                            logic [1:0] kind, tData expWord);
      tStim entry;
      entry.addr    = addr;
      entry.data    = data;
      entry.byteEn  = byteEn;
      entry.wr      = wr;
      entry.rd      = rd;
      entry.kind    = kind;
      entry.expWord = expWord;
      entry.sw      = swNow;  // Board inputs ride along with every entry
      entry.btn     = btnNow;
      stimTable.push_back(entry);
   endtask

   task automatic idleCycles(int count);
      repeat (count) pushEntry('0, '0, '0, 1'b0, 1'b0, CHK_NONE, '0);
   endtask

   task automatic writeWord(tAddr addr, tData data, tByteEn byteEn);
      int   idx;
      tData merged;
      if (addr[31:16] == RAM_BASE[31:16]) begin
         idx            = (addr[15:0] >> 2) % RAM_WORDS;  // Aliases past RAM_WORDS
         ramShadow[idx] = byteMerge(ramShadow[idx], data, byteEn);
      end else if (addr[31:16] == VGA_BASE[31:16]) begin
         idx           = (addr[15:0] >> 2) % FB_WORDS;
         fbShadow[idx] = byteMerge(fbShadow[idx], data, byteEn);
      end else if (addr[31:16] == CR_BASE[31:16]) begin
         if (addr[15:0] == CR_LED) begin
            merged    = byteMerge(tData'(ledShadow), data, byteEn);
            ledShadow = merged[9:0];
         end else if (addr[15:0] == CR_SEG) begin
            merged    = byteMerge(tData'(segShadow), data, byteEn);
            segShadow = merged[23:0];
         end
      end
      pushEntry(addr, data, byteEn, 1'b1, 1'b0, CHK_NONE, '0);
   endtask

   task automatic readWord(tAddr addr);
      tData       expWord;
      logic [1:0] kind;
      expWord = '0;  // Unmapped reads return zero
      kind    = CHK_WORD;
      if (addr[31:16] == RAM_BASE[31:16]) begin
         expWord = ramShadow[(addr[15:0] >> 2) % RAM_WORDS];
      end else if (addr[31:16] == VGA_BASE[31:16]) begin
         expWord = fbShadow[(addr[15:0] >> 2) % FB_WORDS];
      end else if (addr[31:16] == CR_BASE[31:16]) begin
         case (addr[15:0])
            CR_LED:  expWord = tData'(ledShadow);
            CR_SEG:  expWord = tData'(segShadow);
            CR_SW:   expWord = tData'(swNow);
            CR_BTN:  expWord = tData'(btnNow);
            CR_VGAX: kind    = CHK_VGAX;
            default: expWord = '0;
         endcase
      end
      pushEntry(addr, '0, '0, 1'b0, 1'b1, kind, expWord);
   endtask

   // New board values, then time for the two-flop synchroniser
   task automatic setBoard(logic [9:0] sw, logic [1:0] btn);
      swNow  = sw;
      btnNow = btn;
      idleCycles(3);
   endtask

   task automatic buildTable();
      // Data RAM, full words then partial lanes
      for (int i = 0; i < 6; i++) writeWord(RAM_BASE + 4 * i, $random(seed), 4'hF);
      for (int i = 0; i < 6; i++) readWord(RAM_BASE + 4 * i);
      for (int i = 0; i < 5; i++) begin
         writeWord(RAM_BASE + 4 * (i + 1), $random(seed), tByteEn'(i * 3 + 1));
         readWord(RAM_BASE + 4 * (i + 1));  // Very next cycle
      end
      writeWord(RAM_BASE + 4 * (RAM_WORDS + 2), $random(seed), 4'hF);
      readWord(RAM_BASE + 8);                // Alias of the word above
      readWord(RAM_BASE + 4 * (RAM_WORDS + 2));
      // Control registers
      writeWord(CR_BASE + CR_LED, $random(seed), 4'hF);
      readWord(CR_BASE + CR_LED);
      writeWord(CR_BASE + CR_SEG, $random(seed), 4'b0011);
      readWord(CR_BASE + CR_SEG);
      writeWord(CR_BASE + CR_SEG, $random(seed), 4'b0100);
      readWord(CR_BASE + CR_SEG);
      setBoard(10'h2A5, 2'b10);
      readWord(CR_BASE + CR_SW);
      readWord(CR_BASE + CR_BTN);
      writeWord(CR_BASE + CR_SW, $random(seed), 4'hF);  // Read only
      readWord(CR_BASE + CR_SW);
      setBoard(10'h15A, 2'b01);
      readWord(CR_BASE + CR_SW);
      readWord(CR_BASE + CR_BTN);
      readWord(CR_BASE + CR_VGAX);
      idleCycles(5);
      readWord(CR_BASE + CR_VGAX);
      readWord(CR_BASE + 16'h0020);          // Unknown offset
      // Frame buffer, every word written so the scan is fully known
      for (int i = 0; i < FB_WORDS; i++) writeWord(VGA_BASE + 4 * i, $random(seed), 4'hF);
      for (int i = 0; i < FB_WORDS; i++) readWord(VGA_BASE + 4 * i);
      writeWord(VGA_BASE + 8, $random(seed), 4'b1001);
      readWord(VGA_BASE + 8);
      // Unmapped space
      readWord(32'h0002_0000);
      readWord(32'h00C1_0010);
      writeWord(32'h0002_0000, $random(seed), 4'hF);
      writeWord(32'h00FE_0004, $random(seed), 4'hF);
      readWord(RAM_BASE);
      readWord(CR_BASE + CR_LED);
      readWord(VGA_BASE + 4);
      idleCycles(2);
   endtask

   //====================
   // Stimulus
   //====================
   initial begin
      reqAddrQ103H   = '0;
      reqDataQ103H   = '0;
      reqByteEnQ103H = '0;
      reqWrEnQ103H   = 1'b0;
      reqRdEnQ103H   = 1'b0;
      switches       = '0;
      buttons        = '0;
      expRdData      = '0;
      checkKind      = CHK_NONE;
      finishRun      = 1'b0;
      seed           = 65;
      swNow          = '0;
      btnNow         = '0;
      ledShadow      = '0;
      segShadow      = '0;
      buildTable();
      wait (rstN === 1'b1);
      foreach (stimTable[i]) begin
         @(posedge Clock);
         reqAddrQ103H   <= stimTable[i].addr;
         reqDataQ103H   <= stimTable[i].data;
         reqByteEnQ103H <= stimTable[i].byteEn;
         reqWrEnQ103H   <= stimTable[i].wr;
         reqRdEnQ103H   <= stimTable[i].rd;
         checkKind      <= stimTable[i].kind;
         expRdData      <= stimTable[i].expWord;
         switches       <= stimTable[i].sw;
         buttons        <= stimTable[i].btn;
      end
      @(posedge Clock);
      reqWrEnQ103H <= 1'b0;
      reqRdEnQ103H <= 1'b0;
      checkKind    <= CHK_NONE;
      repeat (2 * FRAME_CYCLES) @(posedge Clock);  // Scan over the written frame
      finishRun <= 1'b1;
      #1;
      if (errCount == 0 && assertErrs == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // Run limit from the table length and three frames
   initial begin
      int cycleCount;
      int cycleLimit;
      wait (rstN === 1'b1);
      cycleLimit = stimTable.size() + 3 * FRAME_CYCLES + 50;
      cycleCount = 0;
      while (cycleCount < cycleLimit) begin
         @(posedge Clock);
         cycleCount++;
      end
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Regression failed");
      $finish;
   end

endmodule

// File: tb.f
design/dMemPkg.sv
design/regionDecode.sv
design/dataRam.sv
design/crMem.sv
design/vgaCtrl.sv
design/rdRspSel.sv
design/dMemSubsystem.sv
test/tbClock.sv
test/tbMonitor.sv
test/dMemSubsystem_chk.sv
test/tb.sv

// File: Bender.yml
package:
  name: dmem_subsystem

sources:
  - design/dMemPkg.sv
  - design/regionDecode.sv
  - design/dataRam.sv
  - design/crMem.sv
  - design/vgaCtrl.sv
  - design/rdRspSel.sv
  - design/dMemSubsystem.sv
  - target: test
    files:
      - test/tbClock.sv
      - test/tbMonitor.sv
      - test/dMemSubsystem_chk.sv
      - test/tb.sv
